// File: Bender.yml
package:
  name: mem_stage

sources:
  - files:
      - src/memStagePkg.sv
      - src/exMemReg.sv
      - src/memAccessFsm.sv
      - src/waitTimer.sv
      - src/dataMemory.sv
      - src/loadStoreAlign.sv
      - src/memStageResolve.sv
      - src/memStage.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/memStageTb.sv

// File: dv/memStageTbTable.svh
`ifndef MEM_STAGE_TB_TABLE_SVH
`define MEM_STAGE_TB_TABLE_SVH

typedef enum logic [2:0] {
        OpAlu,
        OpStore,
        OpLoad,
        OpBranch,
        OpJump,
        OpFlush
} opKindT;

typedef struct {
        string   name;
        opKindT  kind;
        wordT    addr;
        memSizeT size;
        wordT    data;
        regIdxT  dest;
        logic    link;
        logic    zero;
        logic    jumpReg;
        pcT      pc;
        logic    expValid;
        logic    expRedirect;
        pcT      expPc;
} rowT;

localparam int NumRows = 25;

// Columns: name, kind, addr, size, data, dest, link, zero, jumpReg, pcPlus4,
//          expected wbOut.valid, expected redirectValid, expected redirectPc
// A data value of zero on ALU, store and flush rows is replaced by a random word
rowT testTable [NumRows] = '{
        '{"alu add",       OpAlu,    '0,     SizeWord,  '0,     5'd3,  '0, '0, '0, '0,
          '1, '0, '0},
        '{"alu link",      OpAlu,    '0,     SizeWord,  '0,     5'd31, '1, '0, '0, 32'h204,
          '1, '0, '0},
        '{"sw word",       OpStore,  32'h40, SizeWord,  '0,     '0,    '0, '0, '0, '0,
          '0, '0, '0},
        '{"lw word",       OpLoad,   32'h40, SizeWord,  '0,     5'd4,  '0, '0, '0, '0,
          '1, '0, '0},
        '{"sh lane 0",     OpStore,  32'h80, SizeHalf,  32'h8123, '0,  '0, '0, '0, '0,
          '0, '0, '0},
        '{"sh lane 1",     OpStore,  32'h82, SizeHalf,  32'h7abc, '0,  '0, '0, '0, '0,
          '0, '0, '0},
        '{"lh lane 0",     OpLoad,   32'h80, SizeHalf,  '0,     5'd5,  '0, '0, '0, '0,
          '1, '0, '0},
        '{"lh lane 1",     OpLoad,   32'h82, SizeHalf,  '0,     5'd6,  '0, '0, '0, '0,
          '1, '0, '0},
        '{"sb lane 0",     OpStore,  32'hc0, SizeByte,  32'h85, '0,    '0, '0, '0, '0,
          '0, '0, '0},
        '{"sb lane 1",     OpStore,  32'hc1, SizeByte,  32'h17, '0,    '0, '0, '0, '0,
          '0, '0, '0},
        '{"sb lane 2",     OpStore,  32'hc2, SizeByte,  '0,     '0,    '0, '0, '0, '0,
          '0, '0, '0},
        '{"sb lane 3",     OpStore,  32'hc3, SizeByte,  32'hf0, '0,    '0, '0, '0, '0,
          '0, '0, '0},
        '{"lb lane 0",     OpLoad,   32'hc0, SizeByte,  '0,     5'd7,  '0, '0, '0, '0,
          '1, '0, '0},
        '{"lbu lane 0",    OpLoad,   32'hc0, SizeByteU, '0,     5'd8,  '0, '0, '0, '0,
          '1, '0, '0},
        '{"lb lane 1",     OpLoad,   32'hc1, SizeByte,  '0,     5'd9,  '0, '0, '0, '0,
          '1, '0, '0},
        '{"lbu lane 2",    OpLoad,   32'hc2, SizeByteU, '0,     5'd10, '0, '0, '0, '0,
          '1, '0, '0},
        '{"lb lane 3",     OpLoad,   32'hc3, SizeByte,  '0,     5'd11, '0, '0, '0, '0,
          '1, '0, '0},
        '{"lw bytes",      OpLoad,   32'hc0, SizeWord,  '0,     5'd12, '0, '0, '0, '0,
          '1, '0, '0},
        '{"beq taken",     OpBranch, '0,     SizeWord,  '0,     '0,    '0, '1, '0, 32'h1004,
          '0, '1, 32'h1044},
        '{"beq untaken",   OpBranch, '0,     SizeWord,  '0,     '0,    '0, '0, '0, 32'h1104,
          '0, '0, '0},
        '{"j",             OpJump,   '0,     SizeWord,  '0,     '0,    '0, '0, '0, 32'h2008,
          '0, '1, 32'h2808},
        '{"jr",            OpJump,   '0,     SizeWord,  '0,     '0,    '0, '0, '1, 32'h3000,
          '0, '1, 32'h13000},
        '{"jal",           OpJump,   '0,     SizeWord,  '0,     5'd31, '1, '0, '0, 32'h400c,
          '1, '1, 32'h480c},
        '{"flushed sw",    OpFlush,  32'h40, SizeWord,  '0,     '0,    '0, '0, '0, '0,
          '0, '0, '0},
        '{"lw after flush", OpLoad,  32'h40, SizeWord,  '0,     5'd13, '0, '0, '0, '0,
          '1, '0, '0}
};

`endif

// File: dv/memStageTb.sv
module memStageTb;
        timeunit 1ns;
        timeprecision 1ps;

        import memStagePkg::*;

        `include "memStageTbTable.svh"

        localparam int CycleLimit = NumRows * (MemLatency + 8) + 50;

        logic  Clk;
        logic  reset;
        logic  flush;
        exMemT exIn;
        logic  stall;
        memWbT wbOut;
        logic  redirectValid;
        pcT    redirectPc;

        // Byte-wide copy of the data memory
        logic [7:0] shadowMem [MemWords*4];
        int cycleCount = 0;
        int rowErrors  = 0;
        int passCount  = 0;
        int failCount  = 0;

        memStage dut (
                .Clk           (Clk),
                .reset         (reset),
                .flush         (flush),
                .exIn          (exIn),
                .stall         (stall),
                .wbOut         (wbOut),
                .redirectValid (redirectValid),
                .redirectPc    (redirectPc)
        );

        initial begin
                Clk = 1'b0;
                forever #5 Clk = ~Clk;
        end

        always @(posedge Clk) begin
                cycleCount <= cycleCount + 1;
                if (cycleCount >= CycleLimit) begin
                        $display("Timeout: the table did not finish within %0d cycles", CycleLimit);
                        $display("Checks failed");
                        $finish;
                end
        end

        //////////////////////////////
        // Compare tasks
        //////////////////////////////

        task automatic checkWord(input string what, input wordT expected, input wordT actual);
                if (actual !== expected) begin
                        $display("ERR %s: expected %h, actual %h", what, expected, actual);
                        rowErrors++;
                end
        endtask

        task automatic checkPc(input string what, input pcT expected, input pcT actual);
                if (actual !== expected) begin
                        $display("ERR %s: expected %h, actual %h", what, expected, actual);
                        rowErrors++;
                end
        endtask

        task automatic checkReg(input string what, input regIdxT expected, input regIdxT actual);
                if (actual !== expected) begin
                        $display("ERR %s: expected %0d, actual %0d", what, expected, actual);
                        rowErrors++;
                end
        endtask

        task automatic checkFlag(input string what, input logic expected, input logic actual);
                if (actual !== expected) begin
                        $display("ERR %s: expected %b, actual %b", what, expected, actual);
                        rowErrors++;
                end
        endtask

        task automatic finishTest(input string name);
                if (rowErrors == 0) begin
                        passCount++;
                        $display("PASS %s", name);
                end else begin
                        failCount++;
                        $display("FAIL %s", name);
                end
                rowErrors = 0;
        endtask

        //////////////////////////////
        // Shadow memory model
        //////////////////////////////

        function automatic void storeShadow(input wordT addr, input memSizeT size, input wordT data);
                int base;
                base = int'(addr[MemAddrBits+1:0]);
                case (size)
                        SizeWord: begin
                                for (int b = 0; b < 4; b++) begin
                                        shadowMem[(base & ~3) + b] = data[8*b +: 8];
                                end
                        end
                        // Halves are placed by address bit 1 only
                        SizeHalf: begin
                                shadowMem[base & ~1]       = data[7:0];
                                shadowMem[(base & ~1) + 1] = data[15:8];
                        end
                        default: shadowMem[base] = data[7:0];
                endcase
        endfunction

        function automatic wordT loadShadow(input wordT addr, input memSizeT size);
                int          base;
                logic [15:0] half;
                logic [7:0]  oneByte;
                wordT        result;
                base    = int'(addr[MemAddrBits+1:0]);
                oneByte = shadowMem[base];
                half    = {shadowMem[(base & ~1) + 1], shadowMem[base & ~1]};
                case (size)
                        SizeWord: result = {shadowMem[(base & ~3) + 3], shadowMem[(base & ~3) + 2],
                                            shadowMem[(base & ~3) + 1], shadowMem[base & ~3]};
                        SizeHalf: result = {{16{half[15]}}, half};
                        SizeByte: result = {{24{oneByte[7]}}, oneByte};
                        default:  result = {24'd0, oneByte};
                endcase
                return result;
        endfunction

        //////////////////////////////
        // Row driver
        //////////////////////////////

        function automatic exMemT buildBundle(input rowT r);
                exMemT b;
                b              = '0;
                // Flushed slot also carries write-back and jump bits that only the clear hides
                b.regWrite     = (r.kind == OpAlu) || (r.kind == OpLoad) ||
                                 (r.kind == OpFlush) || r.link;
                b.memToReg     = (r.kind == OpLoad);
                b.memRead      = (r.kind == OpLoad);
                b.memWrite     = (r.kind == OpStore) || (r.kind == OpFlush);
                b.branch       = (r.kind == OpBranch);
                b.zero         = r.zero;
                b.jump         = (r.kind == OpJump) || (r.kind == OpFlush);
                b.jumpReg      = r.jumpReg;
                b.link         = r.link;
                b.memSize      = r.size;
                b.destReg      = r.dest;
                b.aluResult    = (r.kind == OpAlu) ? r.data : r.addr;
                b.storeData    = r.data;
                // Distinct targets so a wrong choice shows up
                b.branchTarget = r.pc + 32'h40;
                b.jumpImm      = r.pc + 32'h800;
                b.jumpRs       = r.pc + 32'h1_0000;
                b.pcPlus4      = r.pc;
                return b;
        endfunction

        task automatic applyRow(input rowT r);
                wordT expData;
                logic isMem;
                isMem   = (r.kind == OpLoad) || (r.kind == OpStore);
                expData = r.link ? r.pc : r.data;
                if (r.kind == OpLoad) begin
                        expData = loadShadow(r.addr, r.size);
                end
                if (r.kind == OpStore) begin
                        storeShadow(r.addr, r.size, r.data);
                end
                @(posedge Clk);
                exIn  <= buildBundle(r);
                flush <= (r.kind == OpFlush);
                @(posedge Clk);
                // Bubble behind the row so the Done cycle reloads nothing
                exIn  <= '0;
                flush <= 1'b0;
                @(negedge Clk);
                checkFlag({r.name, " stall"}, isMem, stall);
                if (isMem) begin
                        checkFlag({r.name, " wb valid in stall"}, 1'b0, wbOut.valid);
                end
                while (stall) begin
                        @(negedge Clk);
                end
                checkFlag({r.name, " wb valid"}, r.expValid, wbOut.valid);
                if (r.expValid) begin
                        checkReg({r.name, " wb dest"}, r.dest, wbOut.destReg);
                        checkWord({r.name, " wb data"}, expData, wbOut.wbData);
                end
                checkFlag({r.name, " redirect"}, r.expRedirect, redirectValid);
                if (r.expRedirect) begin
                        checkPc({r.name, " redirect pc"}, r.expPc, redirectPc);
                end
                finishTest(r.name);
        endtask

        //////////////////////////////
        // Main sequence
        //////////////////////////////

        initial begin
                reset = 1'b1;
                flush = 1'b0;
                exIn  = '0;
                void'($urandom(32'h6b63));
                foreach (testTable[i]) begin
                        if ((testTable[i].kind inside {OpAlu, OpStore, OpFlush}) &&
                            (testTable[i].data == '0)) begin
                                testTable[i].data = $urandom;
                        end
                end
                repeat (8) @(posedge Clk);
                reset <= 1'b0;
                @(negedge Clk);
                checkFlag("reset stall", 1'b0, stall);
                checkFlag("reset wb valid", 1'b0, wbOut.valid);
                checkFlag("reset redirect", 1'b0, redirectValid);
                finishTest("after reset");
                for (int i = 0; i < NumRows; i++) begin
                        applyRow(testTable[i]);
                end
                $display("Tests: %0d passed, %0d failed", passCount, failCount);
                if (failCount == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule

// File: src/dataMemory.sv
module dataMemory (
        input  logic                                Clk,
        input  logic                                reset,
        input  logic                                memReq,
        input  logic                                write,
        input  logic [memStagePkg::MemAddrBits-1:0] wordAddr,
        input  memStagePkg::byteEnT                 byteEn,
        input  memStagePkg::wordT                   writeData,
        output logic                                memAck,
        output memStagePkg::wordT                   readData
);
        import memStagePkg::*;

        wordT mem [MemWords];
        logic reqSeen;
        logic timerStart;
        logic timerExpired;
        logic serve;

        // Rising edge of req arms the response delay
        assign timerStart = memReq && !reqSeen;

        // Expired is still up from the previous access on the start cycle,
        // so only a request already in flight is served
        assign serve = memReq && reqSeen && !memAck && timerExpired;

        waitTimer respDelay (
                .Clk     (Clk),
                .reset   (reset),
                .start   (timerStart),
                .expired (timerExpired)
        );

        //////////////////////////////
        // Array access
        //////////////////////////////

        always_ff @(posedge Clk) begin
                if (serve) begin
                        if (write) begin
                                for (int b = 0; b < $bits(byteEnT); b++) begin
                                        if (byteEn[b]) begin
                                                mem[wordAddr][8*b +: 8] <= writeData[8*b +: 8];
                                        end
                                end
                        end else begin
                                readData <= mem[wordAddr];
                        end
                end
        end

        //////////////////////////////
        // Ack side of the handshake
        //////////////////////////////

        always_ff @(posedge Clk) begin
                if (reset) begin
                        reqSeen <= 1'b0;
                        memAck  <= 1'b0;
                end else begin
                        reqSeen <= memReq;
                        if (serve) begin
                                memAck <= 1'b1;
                        end else if (!memReq) begin
                                memAck <= 1'b0;
                        end
                end
        end

endmodule

// File: src/exMemReg.sv
module exMemReg (
        input  logic               Clk,
        input  logic               reset,
        input  logic               flush,
        input  logic               ld,
        input  memStagePkg::exMemT exIn,
        output memStagePkg::exMemT exMemOut
);

        //////////////////////////////
        // Execute to memory register
        //////////////////////////////

        // Clear beats load, so a flushed slot becomes a bubble
        // even while the stage is held
        always_ff @(posedge Clk) begin
                if (reset || flush) begin
                        exMemOut <= '0;
                end else if (ld) begin
                        exMemOut <= exIn;
                end
        end

endmodule

// File: src/loadStoreAlign.sv
module loadStoreAlign (
        input  memStagePkg::wordT    addr,
        input  memStagePkg::memSizeT size,
        input  memStagePkg::wordT    storeData,
        input  memStagePkg::wordT    rawLoad,
        output memStagePkg::byteEnT  byteEn,
        output memStagePkg::wordT    laneData,
        output memStagePkg::wordT    loadValue
);
        import memStagePkg::*;

        logic [1:0]  lane;
        logic [7:0]  loadByte;
        logic [15:0] loadHalf;

        // Byte offset inside the word
        assign lane = addr[1:0];

        //////////////////////////////
        // Store path
        //////////////////////////////

        // Data is replicated across lanes, the enables pick the one written
        always_comb begin
                case (size)
                        SizeWord: begin
                                byteEn   = '1;
                                laneData = storeData;
                        end
                        SizeHalf: begin
                                byteEn   = lane[1] ? 4'b1100 : 4'b0011;
                                laneData = {2{storeData[15:0]}};
                        end
                        default: begin
                                byteEn   = 4'b0001 << lane;
                                laneData = {4{storeData[7:0]}};
                        end
                endcase
        end

        //////////////////////////////
        // Load path
        //////////////////////////////

        assign loadByte = rawLoad[{lane, 3'b000} +: 8];
        assign loadHalf = lane[1] ? rawLoad[31:16] : rawLoad[15:0];

        always_comb begin
                case (size)
                        SizeWord:  loadValue = rawLoad;
                        SizeHalf:  loadValue = {{16{loadHalf[15]}}, loadHalf};
                        SizeByte:  loadValue = {{24{loadByte[7]}}, loadByte};
                        SizeByteU: loadValue = {24'd0, loadByte};
                        default:   loadValue = rawLoad;
                endcase
        end

endmodule

// File: src/memAccessFsm.sv
module memAccessFsm (
        input  logic Clk,
        input  logic reset,
        input  logic flush,
        input  logic memOp,
        input  logic memAck,
        output logic memReq,
        output logic loadCapture,
        output logic ld,
        output logic stall
);
        import memStagePkg::*;

        stageStateT state;
        stageStateT stateNext;

        //////////////////////////////
        // Next state
        //////////////////////////////

        always_comb begin
                stateNext   = state;
                loadCapture = 1'b0;
                case (state)
                        Idle: begin
                                // Slot being flushed never starts a request
                                if (memOp && !flush) begin
                                        stateNext = Request;
                                end
                        end
                        Request: begin
                                if (memAck) begin
                                        stateNext   = Release;
                                        loadCapture = 1'b1;
                                end
                        end
                        Release: begin
                                // Wait for the memory to drop ack
                                if (!memAck) begin
                                        stateNext = Done;
                                end
                        end
                        Done: begin
                                stateNext = Idle;
                        end
                        default: begin
                                stateNext = Idle;
                        end
                endcase
        end

        //////////////////////////////
        // State and request
        //////////////////////////////

        always_ff @(posedge Clk) begin
                if (reset) begin
                        state  <= Idle;
                        memReq <= 1'b0;
                end else begin
                        state  <= stateNext;
                        memReq <= (stateNext == Request);
                end
        end

        // Hold upstream from capture until the access has finished
        assign stall = (state == Request) || (state == Release) ||
                       ((state == Idle) && memOp);
        assign ld    = !stall;

endmodule

// File: src/memStage.sv
module memStage (
        input  logic               Clk,
        input  logic               reset,
        input  logic               flush,
        input  memStagePkg::exMemT exIn,
        output logic               stall,
        output memStagePkg::memWbT wbOut,
        output logic               redirectValid,
        output memStagePkg::pcT    redirectPc
);
        import memStagePkg::*;

        exMemT  stage;
        logic   ld;
        logic   memOp;
        logic   memReq;
        logic   memAck;
        logic   loadCapture;
        byteEnT byteEn;
        wordT   laneData;
        wordT   rawLoad;
        wordT   loadValue;

        assign memOp = stage.memRead | stage.memWrite;

        exMemReg pipeReg (
                .Clk      (Clk),
                .reset    (reset),
                .flush    (flush),
                .ld       (ld),
                .exIn     (exIn),
                .exMemOut (stage)
        );

        memAccessFsm accessFsm (
                .Clk         (Clk),
                .reset       (reset),
                .flush       (flush),
                .memOp       (memOp),
                .memAck      (memAck),
                .memReq      (memReq),
                .loadCapture (loadCapture),
                .ld          (ld),
                .stall       (stall)
        );

        // Word index drops the byte offset bits
        dataMemory dataMem (
                .Clk       (Clk),
                .reset     (reset),
                .memReq    (memReq),
                .write     (stage.memWrite),
                .wordAddr  (stage.aluResult[MemAddrBits+1:2]),
                .byteEn    (byteEn),
                .writeData (laneData),
                .memAck    (memAck),
                .readData  (rawLoad)
        );

        loadStoreAlign align (
                .addr      (stage.aluResult),
                .size      (stage.memSize),
                .storeData (stage.storeData),
                .rawLoad   (rawLoad),
                .byteEn    (byteEn),
                .laneData  (laneData),
                .loadValue (loadValue)
        );

        memStageResolve resolve (
                .Clk           (Clk),
                .reset         (reset),
                .stage         (stage),
                .loadValue     (loadValue),
                .loadCapture   (loadCapture),
                .stall         (stall),
                .wbOut         (wbOut),
                .redirectValid (redirectValid),
                .redirectPc    (redirectPc)
        );

endmodule

// File: src/memStagePkg.sv
package memStagePkg;

        //////////////////////////////
        // Memory model
        //////////////////////////////

        localparam int MemWords    = 256;
        localparam int MemAddrBits = 8;
        localparam int MemLatency  = 3;

        // Wide enough to hold MemLatency minus one
        localparam int TimerBits   = $clog2(MemLatency);

        //////////////////////////////
        // Vector types
        //////////////////////////////

        typedef logic [31:0]          wordT;
        typedef logic [31:0]          pcT;
        typedef logic [4:0]           regIdxT;
        typedef logic [3:0]           byteEnT;
        typedef logic [TimerBits-1:0] timerT;

        typedef enum logic [1:0] {
                SizeWord  = 2'd0,
                SizeHalf  = 2'd1,
                SizeByte  = 2'd2,
                SizeByteU = 2'd3
        } memSizeT;

        typedef enum logic [1:0] {
                Idle    = 2'd0,
                Request = 2'd1,
                Release = 2'd2,
                Done    = 2'd3
        } stageStateT;

        //////////////////////////////
        // Stage bundles
        //////////////////////////////

        // Execute results and the control bits that travel with them
        typedef struct packed {
                logic    regWrite;
                logic    memToReg;
                logic    memRead;
                logic    memWrite;
                logic    branch;
                logic    zero;
                logic    jump;
                logic    jumpReg;
                logic    link;
                memSizeT memSize;
                regIdxT  destReg;
                wordT    aluResult;
                wordT    storeData;
                pcT      branchTarget;
                pcT      jumpImm;
                pcT      jumpRs;
                pcT      pcPlus4;
        } exMemT;

        typedef struct packed {
                logic   valid;
                regIdxT destReg;
                wordT   wbData;
        } memWbT;

endpackage

// File: src/memStageResolve.sv
module memStageResolve (
        input  logic               Clk,
        input  logic               reset,
        input  memStagePkg::exMemT stage,
        input  memStagePkg::wordT  loadValue,
        input  logic               loadCapture,
        input  logic               stall,
        output memStagePkg::memWbT wbOut,
        output logic               redirectValid,
        output memStagePkg::pcT    redirectPc
);
        import memStagePkg::*;

        wordT loadHeld;

        // Read word is only valid around the ack, keep it for Done
        always_ff @(posedge Clk) begin
                if (reset) begin
                        loadHeld <= '0;
                end else if (loadCapture) begin
                        loadHeld <= loadValue;
                end
        end

        //////////////////////////////
        // Write-back
        //////////////////////////////

        always_comb begin
                wbOut.valid   = stage.regWrite && !stall;
                wbOut.destReg = stage.destReg;
                if (stage.memToReg) begin
                        wbOut.wbData = loadHeld;
                end else if (stage.link) begin
                        wbOut.wbData = stage.pcPlus4;
                end else begin
                        wbOut.wbData = stage.aluResult;
                end
        end

        // Taken branch or any jump
        assign redirectValid = !stall && ((stage.branch && stage.zero) || stage.jump);

        always_comb begin
                if (stage.jump) begin
                        redirectPc = stage.jumpReg ? stage.jumpRs : stage.jumpImm;
                end else begin
                        redirectPc = stage.branchTarget;
                end
        end

endmodule

// File: src/waitTimer.sv
module waitTimer (
        input  logic Clk,
        input  logic reset,
        input  logic start,
        output logic expired
);
        import memStagePkg::*;

        timerT count;
        logic  armed;

        always_ff @(posedge Clk) begin
                if (reset) begin
                        count <= '0;
                        armed <= 1'b0;
                end else if (start) begin
                        count <= timerT'(MemLatency - 1);
                        armed <= 1'b1;
                end else if (count != '0) begin
                        count <= count - 1'b1;
                end
        end

        // Stays up until the next start reloads the count
        assign expired = armed && (count == '0);

endmodule

// File: vlog.f
+incdir+dv
src/memStagePkg.sv
src/exMemReg.sv
src/memAccessFsm.sv
src/waitTimer.sv
src/dataMemory.sv
src/loadStoreAlign.sv
src/memStageResolve.sv
src/memStage.sv
dv/memStageTb.sv
